// File: rtl/intc_settings.svh
// assumes RV32 CSR bit layout with M, S and U modes all present; source index order is priority.
`ifndef INTC_SETTINGS_SVH
`define INTC_SETTINGS_SVH

`define INTC_CSR_W      32
`define INTC_CAUSE_W    10
`define INTC_PRIV_W     2
`define INTC_NUM_SRC    9
`define INTC_NUM_LEVELS 3

`define INTC_PRIV_U 2'd0
`define INTC_PRIV_S 2'd1
`define INTC_PRIV_M 2'd3

// mip/mie bit positions, which are also the cause codes.
`define INTC_BIT_MEI 11
`define INTC_BIT_MSI 3
`define INTC_BIT_MTI 7
`define INTC_BIT_SEI 9
`define INTC_BIT_SSI 1
`define INTC_BIT_STI 5
`define INTC_BIT_UEI 8
`define INTC_BIT_USI 0
`define INTC_BIT_UTI 4

// index into the source vector, lowest index wins.
`define INTC_IDX_MEI 0
`define INTC_IDX_MSI 1
`define INTC_IDX_MTI 2
`define INTC_IDX_SEI 3
`define INTC_IDX_SSI 4
`define INTC_IDX_STI 5
`define INTC_IDX_UEI 6
`define INTC_IDX_USI 7
`define INTC_IDX_UTI 8

`define INTC_LVL_M 0
`define INTC_LVL_S 1
`define INTC_LVL_U 2

`endif

// File: rtl/intc_pkg.sv
// vector types are sized from the settings header, so both must be compiled with the same include path.
`include "intc_settings.svh"

package intc_pkg;

    // raw value of one of the interrupt CSRs (mip, mie, mideleg, sideleg).
    typedef logic [`INTC_CSR_W-1:0] csr_word_t;

    // cause code as reported to the pipe, interrupt bit not included.
    typedef logic [`INTC_CAUSE_W-1:0] cause_code_t;

    // privilege mode in the standard encoding, 2'd2 is never used.
    typedef logic [`INTC_PRIV_W-1:0] priv_t;

    // one bit per standard source, bit 0 is MEI and has the highest priority.
    typedef logic [`INTC_NUM_SRC-1:0] src_vec_t;

endpackage

// File: rtl/intc_level_if.sv
// level-indexed arrays only; each level selector drives its own hit and code element.
`timescale 1ns/1ps
`include "intc_settings.svh"

interface intc_level_if;

    // sources routed to each target level, already qualified by mip and mie.
    intc_pkg::src_vec_t pending [`INTC_NUM_LEVELS];

    // global interrupt enable of each level for the current privilege.
    logic enable [`INTC_NUM_LEVELS];

    logic hit [`INTC_NUM_LEVELS];
    intc_pkg::cause_code_t code [`INTC_NUM_LEVELS];

    modport router (
        output pending,
        output enable
    );

    modport level (
        input  pending,
        output hit,
        output code
    );

    modport arbiter (
        input enable,
        input hit,
        input code
    );

endinterface

// File: rtl/intc_hart_ctrl.sv
// nmi is taken as fully asynchronous; hart_under_reset stays low once init_done has been seen.
`timescale 1ns/1ps

module intc_hart_ctrl (
    input  logic core_clk,
    input  logic core_reset_n,
    input  logic init_done,
    input  logic debugint,
    input  logic resethaltreq,
    input  logic nmi,
    input  logic nmi_taken,
    output logic hart_under_reset,
    output logic halt_latched,
    output logic rf_init,
    output logic epc_init,
    output logic nmi_pending
);

    logic nmi_meta;
    logic nmi_sync;
    logic nmi_rise;
    logic init_strobe;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            hart_under_reset <= 1'b1;
        end else begin
            hart_under_reset <= hart_under_reset & ~init_done;
        end
    end

    // a debug request seen while the hart is held decides which init runs.
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            halt_latched <= 1'b0;
        end else begin
            halt_latched <= hart_under_reset & (debugint | resethaltreq);
        end
    end

    assign init_strobe = hart_under_reset & init_done;
    assign rf_init = init_strobe & ~halt_latched;
    assign epc_init = init_strobe & halt_latched;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            nmi_meta <= 1'b0;
            nmi_sync <= 1'b0;
            nmi_pending <= 1'b0;
        end else begin
            nmi_meta <= nmi;
            nmi_sync <= nmi_meta;
            nmi_pending <= nmi_rise | (nmi_pending & ~nmi_taken);
        end
    end

    // a new edge wins over a take in the same cycle.
    assign nmi_rise = nmi_meta & ~nmi_sync;

endmodule

// File: rtl/intc_router.sv
// CSR inputs are used as given; WARL legalization of mideleg and sideleg is left to the CSR file.
`timescale 1ns/1ps
`include "intc_settings.svh"

module intc_router (
    input  intc_pkg::csr_word_t mip,
    input  intc_pkg::csr_word_t mie,
    input  intc_pkg::csr_word_t mideleg,
    input  intc_pkg::csr_word_t sideleg,
    input  intc_pkg::priv_t     cur_privilege,
    input  logic                mstatus_mie,
    input  logic                mstatus_sie,
    input  logic                mstatus_uie,
    intc_level_if.router        lvl
);

    localparam intc_pkg::src_vec_t machine_src = intc_pkg::src_vec_t'(
        (1 << `INTC_IDX_MEI) | (1 << `INTC_IDX_MSI) | (1 << `INTC_IDX_MTI));
    localparam intc_pkg::src_vec_t user_src = intc_pkg::src_vec_t'(
        (1 << `INTC_IDX_UEI) | (1 << `INTC_IDX_USI) | (1 << `INTC_IDX_UTI));

    intc_pkg::src_vec_t active;
    intc_pkg::src_vec_t to_s;
    intc_pkg::src_vec_t to_u;

    // reorders CSR bits into priority order.
    function automatic intc_pkg::src_vec_t gather(intc_pkg::csr_word_t w);
        intc_pkg::src_vec_t v;
        v[`INTC_IDX_MEI] = w[`INTC_BIT_MEI];
        v[`INTC_IDX_MSI] = w[`INTC_BIT_MSI];
        v[`INTC_IDX_MTI] = w[`INTC_BIT_MTI];
        v[`INTC_IDX_SEI] = w[`INTC_BIT_SEI];
        v[`INTC_IDX_SSI] = w[`INTC_BIT_SSI];
        v[`INTC_IDX_STI] = w[`INTC_BIT_STI];
        v[`INTC_IDX_UEI] = w[`INTC_BIT_UEI];
        v[`INTC_IDX_USI] = w[`INTC_BIT_USI];
        v[`INTC_IDX_UTI] = w[`INTC_BIT_UTI];
        return v;
    endfunction

    assign active = gather(mip) & gather(mie);

    // machine sources can never leave M, and only user sources look at sideleg.
    assign to_s = gather(mideleg) & ~machine_src;
    assign to_u = to_s & gather(sideleg) & user_src;

    assign lvl.pending[`INTC_LVL_M] = active & ~to_s;
    assign lvl.pending[`INTC_LVL_S] = active & to_s & ~to_u;
    assign lvl.pending[`INTC_LVL_U] = active & to_u;

    assign lvl.enable[`INTC_LVL_M] = mstatus_mie | (cur_privilege != `INTC_PRIV_M);
    assign lvl.enable[`INTC_LVL_S] = (cur_privilege == `INTC_PRIV_U)
                                   | ((cur_privilege == `INTC_PRIV_S) & mstatus_sie);
    assign lvl.enable[`INTC_LVL_U] = (cur_privilege == `INTC_PRIV_U) & mstatus_uie;

endmodule

// File: rtl/intc_level_sel.sv
// level must be 0, 1 or 2; the pick ignores the level enable, which the arbiter applies.
`timescale 1ns/1ps
`include "intc_settings.svh"

module intc_level_sel #(
    parameter int level = 0
) (
    intc_level_if.level lvl
);

    intc_pkg::src_vec_t pend;
    intc_pkg::cause_code_t first_code;
    int first_idx;

    assign pend = lvl.pending[level];

    // scan from the bottom so the lowest set index is the one left standing.
    always_comb begin
        first_idx = 0;
        for (int i = `INTC_NUM_SRC - 1; i >= 0; i--) begin
            if (pend[i]) begin
                first_idx = i;
            end
        end
    end

    always_comb begin
        case (first_idx)
            `INTC_IDX_MEI: first_code = intc_pkg::cause_code_t'(`INTC_BIT_MEI);
            `INTC_IDX_MSI: first_code = intc_pkg::cause_code_t'(`INTC_BIT_MSI);
            `INTC_IDX_MTI: first_code = intc_pkg::cause_code_t'(`INTC_BIT_MTI);
            `INTC_IDX_SEI: first_code = intc_pkg::cause_code_t'(`INTC_BIT_SEI);
            `INTC_IDX_SSI: first_code = intc_pkg::cause_code_t'(`INTC_BIT_SSI);
            `INTC_IDX_STI: first_code = intc_pkg::cause_code_t'(`INTC_BIT_STI);
            `INTC_IDX_UEI: first_code = intc_pkg::cause_code_t'(`INTC_BIT_UEI);
            `INTC_IDX_USI: first_code = intc_pkg::cause_code_t'(`INTC_BIT_USI);
            `INTC_IDX_UTI: first_code = intc_pkg::cause_code_t'(`INTC_BIT_UTI);
            default: first_code = '0;
        endcase
    end

    assign lvl.hit[level] = |pend;
    assign lvl.code[level] = lvl.hit[level] ? first_code : '0;

endmodule

// File: rtl/intc_arbiter.sv
// purely combinational; the level valids may be high together and the pipe picks by int_code.
`timescale 1ns/1ps
`include "intc_settings.svh"

module intc_arbiter (
    input  logic                  hart_under_reset,
    input  logic                  halt_latched,
    input  logic                  nmi_pending,
    input  logic                  halt_mode,
    input  logic                  dcsr_debugint,
    input  logic                  dcsr_step,
    input  logic                  dcsr_stepie,
    intc_level_if.arbiter         lvl,
    output logic                  debugint_valid,
    output logic                  nmi_valid,
    output logic                  mint_valid,
    output logic                  sint_valid,
    output logic                  uint_valid,
    output logic                  async_valid,
    output logic                  wfi_done,
    output intc_pkg::cause_code_t int_code
);

    logic debug_req;
    logic step_block;
    logic int_allow;
    logic any_hit;

    // a halt request latched at reset turns into a debug entry once the hart is out.
    assign debug_req = (~halt_mode & dcsr_debugint) | halt_latched;
    assign step_block = dcsr_step & ~dcsr_stepie;

    assign debugint_valid = ~hart_under_reset & debug_req;
    assign nmi_valid = ~hart_under_reset & ~debug_req & ~step_block & nmi_pending;
    assign int_allow = ~hart_under_reset & ~debug_req & ~step_block & ~nmi_pending;

    assign mint_valid = int_allow & lvl.enable[`INTC_LVL_M] & lvl.hit[`INTC_LVL_M];
    assign sint_valid = int_allow & lvl.enable[`INTC_LVL_S] & lvl.hit[`INTC_LVL_S];
    assign uint_valid = int_allow & lvl.enable[`INTC_LVL_U] & lvl.hit[`INTC_LVL_U];

    assign async_valid = hart_under_reset | debugint_valid | nmi_valid
                       | mint_valid | sint_valid | uint_valid;

    // wake-up ignores the global enables, as WFI must resume on any pending source.
    assign any_hit = lvl.hit[`INTC_LVL_M] | lvl.hit[`INTC_LVL_S] | lvl.hit[`INTC_LVL_U];
    assign wfi_done = debug_req | nmi_pending | any_hit;

    always_comb begin
        if (lvl.hit[`INTC_LVL_M]) begin
            int_code = lvl.code[`INTC_LVL_M];
        end else if (lvl.hit[`INTC_LVL_S]) begin
            int_code = lvl.code[`INTC_LVL_S];
        end else if (lvl.hit[`INTC_LVL_U]) begin
            int_code = lvl.code[`INTC_LVL_U];
        end else begin
            int_code = '0;
        end
    end

endmodule

// File: rtl/intc_top.sv
// nmi is synchronized inside; all other inputs must be synchronous to core_clk.
`timescale 1ns/1ps
`include "intc_settings.svh"

module intc_top (
    input  logic                  core_clk,
    input  logic                  core_reset_n,
    input  logic                  init_done,
    input  logic                  debugint,
    input  logic                  resethaltreq,
    input  logic                  halt_mode,
    input  logic                  dcsr_step,
    input  logic                  dcsr_stepie,
    input  logic                  nmi,
    input  logic                  nmi_taken,
    input  intc_pkg::priv_t       cur_privilege,
    input  logic                  mstatus_mie,
    input  logic                  mstatus_sie,
    input  logic                  mstatus_uie,
    input  intc_pkg::csr_word_t   mip,
    input  intc_pkg::csr_word_t   mie,
    input  intc_pkg::csr_word_t   mideleg,
    input  intc_pkg::csr_word_t   sideleg,
    output logic                  hart_under_reset,
    output logic                  rf_init,
    output logic                  epc_init,
    output logic                  nmi_pending,
    output logic                  debugint_valid,
    output logic                  nmi_valid,
    output logic                  mint_valid,
    output logic                  sint_valid,
    output logic                  uint_valid,
    output logic                  async_valid,
    output logic                  wfi_done,
    output intc_pkg::cause_code_t int_code
);

    logic halt_latched;

    intc_level_if lvl_if ();

    intc_hart_ctrl hart_ctrl_inst (
        .core_clk         (core_clk),
        .core_reset_n     (core_reset_n),
        .init_done        (init_done),
        .debugint         (debugint),
        .resethaltreq     (resethaltreq),
        .nmi              (nmi),
        .nmi_taken        (nmi_taken),
        .hart_under_reset (hart_under_reset),
        .halt_latched     (halt_latched),
        .rf_init          (rf_init),
        .epc_init         (epc_init),
        .nmi_pending      (nmi_pending)
    );

    intc_router router_inst (
        .mip           (mip),
        .mie           (mie),
        .mideleg       (mideleg),
        .sideleg       (sideleg),
        .cur_privilege (cur_privilege),
        .mstatus_mie   (mstatus_mie),
        .mstatus_sie   (mstatus_sie),
        .mstatus_uie   (mstatus_uie),
        .lvl           (lvl_if.router)
    );

    // one selector per target level, each owning its slice of the interface.
    for (genvar l = 0; l < `INTC_NUM_LEVELS; l++) begin : gen_level
        intc_level_sel #(.level(l)) level_sel_inst (.lvl(lvl_if.level));
    end

    intc_arbiter arbiter_inst (
        .hart_under_reset (hart_under_reset),
        .halt_latched     (halt_latched),
        .nmi_pending      (nmi_pending),
        .halt_mode        (halt_mode),
        .dcsr_debugint    (debugint),
        .dcsr_step        (dcsr_step),
        .dcsr_stepie      (dcsr_stepie),
        .lvl              (lvl_if.arbiter),
        .debugint_valid   (debugint_valid),
        .nmi_valid        (nmi_valid),
        .mint_valid       (mint_valid),
        .sint_valid       (sint_valid),
        .uint_valid       (uint_valid),
        .async_valid      (async_valid),
        .wfi_done         (wfi_done),
        .int_code         (int_code)
    );

endmodule

// File: sim/intc_clkgen.sv
// free-running 20 ns clock; apply_reset can be called again from the testbench to reset mid-run.
`timescale 1ns/1ps

module intc_clkgen (
    output logic core_clk,
    output logic core_reset_n
);

    // reset is held low over eight rising edges and released 2 ns after the last one.
    task automatic apply_reset();
        core_reset_n = 1'b0;
        repeat (8) @(posedge core_clk);
        #2;
        core_reset_n = 1'b1;
    endtask

    initial begin
        core_clk = 1'b0;
        core_reset_n = 1'b1;
        #1;
        apply_reset();
    end

    always #10 core_clk = ~core_clk;

endmodule

// File: sim/intc_checker.sv
// samples at each rising core_clk edge and expects all inputs to be settled well before it.
`timescale 1ns/1ps
`include "intc_settings.svh"

module intc_checker (
    input logic                  core_clk,
    input logic                  core_reset_n,
    input logic                  init_done,
    input logic                  debugint,
    input logic                  resethaltreq,
    input logic                  halt_mode,
    input logic                  dcsr_step,
    input logic                  dcsr_stepie,
    input logic                  nmi,
    input logic                  nmi_taken,
    input intc_pkg::priv_t       cur_privilege,
    input logic                  mstatus_mie,
    input logic                  mstatus_sie,
    input logic                  mstatus_uie,
    input intc_pkg::csr_word_t   mip,
    input intc_pkg::csr_word_t   mie,
    input intc_pkg::csr_word_t   mideleg,
    input intc_pkg::csr_word_t   sideleg,
    input logic                  hart_under_reset,
    input logic                  rf_init,
    input logic                  epc_init,
    input logic                  nmi_pending,
    input logic                  debugint_valid,
    input logic                  nmi_valid,
    input logic                  mint_valid,
    input logic                  sint_valid,
    input logic                  uint_valid,
    input logic                  async_valid,
    input logic                  wfi_done,
    input intc_pkg::cause_code_t int_code
);

    localparam int bit_pos [`INTC_NUM_SRC] = '{`INTC_BIT_MEI, `INTC_BIT_MSI, `INTC_BIT_MTI,
        `INTC_BIT_SEI, `INTC_BIT_SSI, `INTC_BIT_STI, `INTC_BIT_UEI, `INTC_BIT_USI, `INTC_BIT_UTI};

    int fail_count = 0;
    logic reset_m;
    logic halt_m;
    logic [1:0] nmi_hist;
    logic pend_m;
    logic debug_m;
    logic allow_m;
    logic [2:0] hit_m;
    logic [2:0] en_m;
    logic [2:0] exp_lvl;
    logic [2:0] act_lvl;
    logic [1:0] exp_init;
    logic [1:0] exp_arb;
    logic exp_async;
    logic exp_wfi;
    intc_pkg::cause_code_t code_m;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            reset_m <= 1'b1;
            halt_m <= 1'b0;
            nmi_hist <= 2'b00;
            pend_m <= 1'b0;
        end else begin
            reset_m <= reset_m & ~init_done;
            halt_m <= reset_m & (debugint | resethaltreq);
            nmi_hist <= {nmi_hist[0], nmi};
            pend_m <= (nmi_hist[0] & ~nmi_hist[1]) | (pend_m & ~nmi_taken);
        end
    end

    // walks U to M and high to low index, so the winning source is written last.
    always_comb begin
        int tgt;
        hit_m = '0;
        code_m = '0;
        for (int l = `INTC_NUM_LEVELS - 1; l >= 0; l--) begin
            for (int s = `INTC_NUM_SRC - 1; s >= 0; s--) begin
                tgt = (s < `INTC_IDX_SEI || !mideleg[bit_pos[s]]) ? `INTC_LVL_M
                    : (s < `INTC_IDX_UEI || !sideleg[bit_pos[s]]) ? `INTC_LVL_S : `INTC_LVL_U;
                if (tgt == l && mip[bit_pos[s]] && mie[bit_pos[s]]) begin
                    hit_m[l] = 1'b1;
                    code_m = intc_pkg::cause_code_t'(bit_pos[s]);
                end
            end
        end
    end

    assign en_m[`INTC_LVL_M] = mstatus_mie || cur_privilege != `INTC_PRIV_M;
    assign en_m[`INTC_LVL_S] = cur_privilege == `INTC_PRIV_U
                             || (cur_privilege == `INTC_PRIV_S && mstatus_sie);
    assign en_m[`INTC_LVL_U] = cur_privilege == `INTC_PRIV_U && mstatus_uie;

    assign debug_m = (!halt_mode && debugint) || halt_m;
    assign allow_m = !reset_m && !debug_m && !(dcsr_step && !dcsr_stepie);
    assign exp_init = {reset_m & init_done & halt_m, reset_m & init_done & ~halt_m};
    assign exp_arb = {~reset_m & debug_m, allow_m & pend_m};
    assign exp_lvl = {3{allow_m & ~pend_m}} & hit_m & en_m;
    assign act_lvl = {uint_valid, sint_valid, mint_valid};
    assign exp_async = reset_m | (|exp_arb) | (|exp_lvl);
    assign exp_wfi = debug_m | pend_m | (|hit_m);

    a_reset: assert property (@(posedge core_clk) hart_under_reset == reset_m) else begin
        fail_count++;
        $error("ERROR hart_under_reset exp %h got %h", $sampled(reset_m), $sampled(hart_under_reset));
    end

    a_init: assert property (@(posedge core_clk) {epc_init, rf_init} == exp_init) else begin
        fail_count++;
        $error("ERROR epc_init/rf_init exp %h got %h", $sampled(exp_init),
            $sampled({epc_init, rf_init}));
    end

    a_nmi: assert property (@(posedge core_clk) nmi_pending == pend_m) else begin
        fail_count++;
        $error("ERROR nmi_pending exp %h got %h", $sampled(pend_m), $sampled(nmi_pending));
    end

    a_arb: assert property (@(posedge core_clk) {debugint_valid, nmi_valid} == exp_arb) else begin
        fail_count++;
        $error("ERROR debugint_valid/nmi_valid exp %h got %h", $sampled(exp_arb),
            $sampled({debugint_valid, nmi_valid}));
    end

    a_lvl: assert property (@(posedge core_clk) act_lvl == exp_lvl) else begin
        fail_count++;
        $error("ERROR uint/sint/mint_valid exp %h got %h", $sampled(exp_lvl), $sampled(act_lvl));
    end

    a_async: assert property (@(posedge core_clk) async_valid == exp_async) else begin
        fail_count++;
        $error("ERROR async_valid exp %h got %h", $sampled(exp_async), $sampled(async_valid));
    end

    a_wfi: assert property (@(posedge core_clk) wfi_done == exp_wfi) else begin
        fail_count++;
        $error("ERROR wfi_done exp %h got %h", $sampled(exp_wfi), $sampled(wfi_done));
    end

    a_code: assert property (@(posedge core_clk) int_code == code_m) else begin
        fail_count++;
        $error("ERROR int_code exp %h got %h", $sampled(code_m), $sampled(int_code));
    end

endmodule

bind intc_top intc_checker rules_chk (.*);

// File: sim/intc_tb.sv
// inputs change 2 ns after each rising edge; pass or fail depends only on the bound checker count.
`timescale 1ns/1ps
`include "intc_settings.svh"

module intc_tb;

    localparam int phase_cycles = 60;
    localparam int random_cycles = 400;

    logic core_clk;
    logic core_reset_n;
    logic init_done;
    logic debugint;
    logic resethaltreq;
    logic halt_mode;
    logic dcsr_step;
    logic dcsr_stepie;
    logic nmi;
    logic nmi_taken;
    intc_pkg::priv_t cur_privilege;
    logic mstatus_mie;
    logic mstatus_sie;
    logic mstatus_uie;
    intc_pkg::csr_word_t mip;
    intc_pkg::csr_word_t mie;
    intc_pkg::csr_word_t mideleg;
    intc_pkg::csr_word_t sideleg;
    logic hart_under_reset;
    logic rf_init;
    logic epc_init;
    logic nmi_pending;
    logic debugint_valid;
    logic nmi_valid;
    logic mint_valid;
    logic sint_valid;
    logic uint_valid;
    logic async_valid;
    logic wfi_done;
    intc_pkg::cause_code_t int_code;

    intc_clkgen clkgen_inst (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n)
    );

    intc_top intc_top_inst (.*);

    task automatic wait_cycles(int n);
        repeat (n) @(posedge core_clk);
        #2;
    endtask

    // debug, step and nmi are kept rare so that the level valids still get exercised.
    task automatic drive_random();
        int pick;
        pick = $urandom_range(0, 2);
        cur_privilege = (pick == 2) ? `INTC_PRIV_M : intc_pkg::priv_t'(pick);
        mip = $urandom();
        mie = $urandom();
        mideleg = $urandom();
        sideleg = $urandom();
        mstatus_mie = 1'($urandom_range(0, 1));
        mstatus_sie = 1'($urandom_range(0, 1));
        mstatus_uie = 1'($urandom_range(0, 1));
        halt_mode = ($urandom_range(0, 3) == 0);
        debugint = ($urandom_range(0, 15) == 0);
        dcsr_step = ($urandom_range(0, 7) == 0);
        dcsr_stepie = 1'($urandom_range(0, 1));
        nmi = ($urandom_range(0, 7) == 0);
        nmi_taken = 1'($urandom_range(0, 1));
    endtask

    initial begin
        void'($urandom(5));
        init_done = 1'b0;
        debugint = 1'b0;
        resethaltreq = 1'b0;
        halt_mode = 1'b0;
        dcsr_step = 1'b0;
        dcsr_stepie = 1'b0;
        nmi = 1'b0;
        nmi_taken = 1'b0;
        cur_privilege = `INTC_PRIV_M;
        mstatus_mie = 1'b0;
        mstatus_sie = 1'b0;
        mstatus_uie = 1'b0;
        mip = '0;
        mie = '0;
        mideleg = '0;
        sideleg = '0;

        // register-file init, no halt request while under reset.
        wait (core_reset_n === 1'b0);
        @(posedge core_reset_n);
        wait_cycles(2);
        init_done = 1'b1;
        wait_cycles(1);
        init_done = 1'b0;
        wait_cycles(2);

        // second reset with a halt request held, so the EPC init runs instead.
        clkgen_inst.apply_reset();
        resethaltreq = 1'b1;
        wait_cycles(2);
        init_done = 1'b1;
        wait_cycles(1);
        init_done = 1'b0;
        resethaltreq = 1'b0;
        wait_cycles(3);

        // nmi, then step block, debug under the step block, debug alone, and debug in halt mode.
        nmi = 1'b1;
        wait_cycles(3);
        dcsr_step = 1'b1;
        wait_cycles(2);
        debugint = 1'b1;
        wait_cycles(2);
        dcsr_step = 1'b0;
        wait_cycles(2);
        halt_mode = 1'b1;
        wait_cycles(2);
        debugint = 1'b0;
        halt_mode = 1'b0;
        nmi_taken = 1'b1;
        wait_cycles(1);
        nmi_taken = 1'b0;
        nmi = 1'b0;
        wait_cycles(2);

        // all nine sources pending; first in M, then blocked by mstatus, then spread over levels.
        mip = 32'h0000_0bbb;
        mie = 32'h0000_0bbb;
        mstatus_mie = 1'b1;
        wait_cycles(2);
        mstatus_mie = 1'b0;
        wait_cycles(2);
        cur_privilege = `INTC_PRIV_U;
        mideleg = '1;
        sideleg = '1;
        mstatus_uie = 1'b1;
        wait_cycles(2);
        dcsr_step = 1'b1;
        wait_cycles(2);
        dcsr_stepie = 1'b1;
        wait_cycles(2);
        debugint = 1'b1;
        wait_cycles(2);
        debugint = 1'b0;
        dcsr_step = 1'b0;
        dcsr_stepie = 1'b0;
        mip = '0;
        wait_cycles(2);

        repeat (random_cycles) begin
            drive_random();
            wait_cycles(1);
        end

        $display("checker failures: %0d", intc_top_inst.rules_chk.fail_count);
        if (intc_top_inst.rules_chk.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(2 * (phase_cycles + random_cycles) * 20);
        $display("timeout: the run did not reach the end of its random phase in time");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+rtl
rtl/intc_pkg.sv
rtl/intc_level_if.sv
rtl/intc_hart_ctrl.sv
rtl/intc_router.sv
rtl/intc_level_sel.sv
rtl/intc_arbiter.sv
rtl/intc_top.sv
sim/intc_clkgen.sv
sim/intc_checker.sv
sim/intc_tb.sv
